// File: design/axi_rd_pkg.sv
/*
 * AXI read side definitions shared by the frame reader blocks.
 * Bus widths, burst encoding and the request and read beat structs.
 */
package axi_rd_pkg;

    localparam int ADDR_W     = 28;
    localparam int DATA_W     = 256;

    localparam int BURST_LEN  = 2;              // beats per burst
    localparam int ADDR_STEP  = BURST_LEN * 8;  // address units per burst

    localparam logic [2:0] BURST_SIZE_CODE = 3'd5;   // 32 byte beats
    localparam logic [1:0] BURST_INCR      = 2'b01;

    localparam int FIFO_DEPTH = 4;

    // one queued read burst, length is fixed
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } ar_req_t;

    // one returned read beat
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } rd_beat_t;

endpackage

// File: design/video_pkg.sv
/*
 * Layout of the multi-view frame in memory.
 * Four quarter-size regions sit side by side at a fixed stride, and the
 * three-quarter-size region follows them. Geometry is scaled down for simulation.
 * Also holds the line sequencer state type.
 */
package video_pkg;

    // quarter-size regions
    localparam int NUM_QD        = 4;
    localparam int QD_LINE_SPAN  = 32;    // words per quarter line
    localparam int QD_LINES      = 4;
    localparam int REGION_STRIDE = 2048;  // region k starts at k * stride

    // three-quarter-size region
    localparam int TC_LINE_SPAN  = 96;
    localparam int TC_LINES      = 6;
    localparam int TC_BASE       = 8192;

    // second frame copy, selected by frame_sel
    localparam int FRAME_OFS_QD  = 1024;
    localparam int FRAME_OFS_TC  = 4096;

    // line sequencer states
    typedef enum logic [1:0] {
        IDLE,        // waiting for a line job
        LINE_PRE,    // load segment start address
        LINE_ISSUE,  // push bursts of one segment
        FRAME_DONE   // large region finished, wait for vsync
    } seq_state_e;

endpackage

// File: design/line_sequencer.sv
/*
 * Turns display sync into read burst requests.
 * Each falling edge of vsync or href starts a line job: one line from each
 * quarter region in turn, or one line of the large region once the quarters
 * are done. A rising edge of vsync restarts the frame.
 */
`timescale 1ns/100ps

module line_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                hsync_in,    // carries vsync
    input  logic                href_in,
    input  logic                frame_sel,
    input  logic                req_ready,
    output logic                req_valid,
    output axi_rd_pkg::ar_req_t req
);

    logic vs_d1, vs_d2;
    logic hr_d1, hr_d2;
    logic vs_rise, vs_fall, hr_fall, line_start;

    video_pkg::seq_state_e state;

    logic [1:0] qd_idx;   // quarter region, NUM_QD is 4
    logic       tc_sel;   // current job reads the large region
    logic [axi_rd_pkg::ADDR_W-1:0] qd_ofs [video_pkg::NUM_QD];
    logic [axi_rd_pkg::ADDR_W-1:0] tc_ofs;

    logic [axi_rd_pkg::ADDR_W-1:0] step;
    logic [axi_rd_pkg::ADDR_W-1:0] cur_ofs;
    logic [axi_rd_pkg::ADDR_W-1:0] region_base;
    logic [axi_rd_pkg::ADDR_W-1:0] frame_ofs;
    logic [7:0]                    seg_left;   // bursts left after the current one
    logic push, seg_last, tc_last, qd_done;

    axi_rd_pkg::ar_req_t req_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            vs_d1 <= 1'b0;
            vs_d2 <= 1'b0;
            hr_d1 <= 1'b0;
            hr_d2 <= 1'b0;
        end else begin
            vs_d1 <= hsync_in;
            vs_d2 <= vs_d1;
            hr_d1 <= href_in;
            hr_d2 <= hr_d1;
        end
    end

    assign vs_rise    = vs_d1 && !vs_d2;
    assign vs_fall    = !vs_d1 && vs_d2;
    assign hr_fall    = !hr_d1 && hr_d2;
    assign line_start = vs_fall || hr_fall;

    assign step    = axi_rd_pkg::ADDR_W'(axi_rd_pkg::ADDR_STEP);
    assign cur_ofs = tc_sel ? tc_ofs : qd_ofs[qd_idx];

    assign region_base = tc_sel ? axi_rd_pkg::ADDR_W'(video_pkg::TC_BASE)
                                : axi_rd_pkg::ADDR_W'(qd_idx * video_pkg::REGION_STRIDE);
    assign frame_ofs   = tc_sel ? axi_rd_pkg::ADDR_W'(video_pkg::FRAME_OFS_TC)
                                : axi_rd_pkg::ADDR_W'(video_pkg::FRAME_OFS_QD);

    // last quarter region has read all its lines
    assign qd_done  = qd_ofs[video_pkg::NUM_QD-1] ==
                      axi_rd_pkg::ADDR_W'(video_pkg::QD_LINES * video_pkg::QD_LINE_SPAN);
    assign tc_last  = (tc_ofs + step) ==
                      axi_rd_pkg::ADDR_W'(video_pkg::TC_LINES * video_pkg::TC_LINE_SPAN);
    assign seg_last = (seg_left == 8'd0);

    assign req_valid = (state == video_pkg::LINE_ISSUE);
    assign push      = req_valid && req_ready;
    assign req       = req_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= video_pkg::IDLE;
            qd_idx   <= 2'd0;
            tc_sel   <= 1'b0;
            tc_ofs   <= '0;
            seg_left <= 8'd0;
            req_q    <= '0;
            for (int i = 0; i < video_pkg::NUM_QD; i++) begin
                qd_ofs[i] <= '0;
            end
        end else if (vs_rise) begin
            // new frame, start over from region 0
            state  <= video_pkg::IDLE;
            qd_idx <= 2'd0;
            tc_sel <= 1'b0;
            tc_ofs <= '0;
            for (int i = 0; i < video_pkg::NUM_QD; i++) begin
                qd_ofs[i] <= '0;
            end
        end else begin
            case (state)
                video_pkg::IDLE: begin
                    if (line_start) begin
                        tc_sel <= qd_done;
                        qd_idx <= 2'd0;
                        state  <= video_pkg::LINE_PRE;
                    end
                end
                video_pkg::LINE_PRE: begin
                    req_q.addr <= region_base + (frame_sel ? frame_ofs : '0) + cur_ofs;
                    seg_left   <= tc_sel
                        ? 8'(video_pkg::TC_LINE_SPAN / axi_rd_pkg::ADDR_STEP - 1)
                        : 8'(video_pkg::QD_LINE_SPAN / axi_rd_pkg::ADDR_STEP - 1);
                    state      <= video_pkg::LINE_ISSUE;
                end
                video_pkg::LINE_ISSUE: begin
                    if (push) begin
                        req_q.addr <= req_q.addr + step;
                        seg_left   <= seg_left - 8'd1;
                        if (tc_sel) begin
                            tc_ofs <= tc_ofs + step;
                        end else begin
                            qd_ofs[qd_idx] <= qd_ofs[qd_idx] + step;
                        end
                        if (seg_last) begin
                            if (tc_sel) begin
                                state <= tc_last ? video_pkg::FRAME_DONE : video_pkg::IDLE;
                            end else if (qd_idx == 2'(video_pkg::NUM_QD - 1)) begin
                                state <= video_pkg::IDLE;
                            end else begin
                                qd_idx <= qd_idx + 2'd1;   // next quarter region
                                state  <= video_pkg::LINE_PRE;
                            end
                        end
                    end
                end
                video_pkg::FRAME_DONE: begin
                    state <= video_pkg::FRAME_DONE;   // only vsync leaves here
                end
                default: begin
                    state <= video_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

// File: design/request_fifo.sv
/*
 * Queue of read burst requests between the line sequencer and the AR issuer.
 * Lets the sequencer run ahead so several bursts stay in flight.
 * out_valid rises one cycle after the first push.
 */
`timescale 1ns/100ps

module request_fifo (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  axi_rd_pkg::ar_req_t in_req,
    output logic                in_ready,
    output logic                out_valid,
    input  logic                out_ready,
    output axi_rd_pkg::ar_req_t out_req
);

    axi_rd_pkg::ar_req_t mem [axi_rd_pkg::FIFO_DEPTH];

    logic [1:0] wr_ptr;   // sized for FIFO_DEPTH of 4
    logic [1:0] rd_ptr;
    logic [2:0] count;
    logic       push, pop;

    assign out_valid = (count != 3'd0);
    // a full queue still takes a request in the cycle it hands one out
    assign in_ready  = (count != 3'(axi_rd_pkg::FIFO_DEPTH)) || out_ready;
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_req   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_req;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= 2'd0;
            rd_ptr <= 2'd0;
            count  <= 3'd0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 2'd1;   // wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 2'd1;
            end
            count <= count + 3'(push) - 3'(pop);
        end
    end

endmodule

// File: design/ar_issuer.sv
/*
 * Drives the AXI read address channel from the request queue and
 * forwards returned read beats to the line buffer write port.
 * A request is popped one cycle before arvalid rises; data lags rvalid by one cycle.
 */
`timescale 1ns/100ps

module ar_issuer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              in_valid,
    input  axi_rd_pkg::ar_req_t               in_req,
    output logic                              in_ready,
    output logic                              axi_arvalid,
    input  logic                              axi_arready,
    output logic [axi_rd_pkg::ADDR_W-1:0]     axi_araddr,
    output logic [3:0]                        axi_arlen,
    output logic [2:0]                        axi_arsize,
    output logic [1:0]                        axi_arburst,
    output logic                              axi_rready,
    input  logic                              axi_rvalid,
    input  logic [axi_rd_pkg::DATA_W-1:0]     axi_rdata,
    input  logic                              axi_rlast,
    output logic                              buf_wr_en,
    output logic [axi_rd_pkg::DATA_W-1:0]     buf_wr_data
);

    logic                 arvalid_q;
    logic                 pop;
    axi_rd_pkg::ar_req_t  ar_q;
    axi_rd_pkg::rd_beat_t beat_q;
    logic                 wr_en_q;

    // channel empty, or its request leaves this cycle
    assign in_ready = !arvalid_q || axi_arready;
    assign pop      = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            arvalid_q <= 1'b0;
            wr_en_q   <= 1'b0;
        end else begin
            if (pop) begin
                arvalid_q <= 1'b1;
            end else if (axi_arready) begin
                arvalid_q <= 1'b0;
            end
            wr_en_q <= axi_rvalid;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            ar_q <= in_req;
        end
        beat_q.data <= axi_rdata;
        beat_q.last <= axi_rlast;
    end

    assign axi_arvalid = arvalid_q;
    assign axi_araddr  = ar_q.addr;
    assign axi_arlen   = 4'(axi_rd_pkg::BURST_LEN - 1);
    assign axi_arsize  = axi_rd_pkg::BURST_SIZE_CODE;
    assign axi_arburst = axi_rd_pkg::BURST_INCR;
    assign axi_rready  = 1'b1;   // line buffer always takes data

    assign buf_wr_en   = wr_en_q;
    assign buf_wr_data = beat_q.data;

endmodule

// File: design/frame_reader.sv
/*
 * Video frame reader top level.
 * Sync timing drives the line sequencer, requests queue in a small FIFO,
 * and the AR issuer puts them on the AXI read address channel.
 * Read data goes on to the line buffer write port.
 */
`timescale 1ns/100ps

module frame_reader (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          vsync,
    input  logic                          href,
    input  logic                          frame_sel,
    output logic                          axi_arvalid,
    input  logic                          axi_arready,
    output logic [axi_rd_pkg::ADDR_W-1:0] axi_araddr,
    output logic [3:0]                    axi_arlen,
    output logic [2:0]                    axi_arsize,
    output logic [1:0]                    axi_arburst,
    output logic                          axi_rready,
    input  logic                          axi_rvalid,
    input  logic [axi_rd_pkg::DATA_W-1:0] axi_rdata,
    input  logic                          axi_rlast,
    output logic                          buf_wr_en,
    output logic [axi_rd_pkg::DATA_W-1:0] buf_wr_data
);

    logic                seq_valid;
    logic                seq_ready;
    axi_rd_pkg::ar_req_t seq_req;
    logic                fifo_valid;
    logic                fifo_ready;
    axi_rd_pkg::ar_req_t fifo_req;

    line_sequencer i_line_sequencer (
        .clk       (clk),
        .rst       (rst),
        .hsync_in  (vsync),
        .href_in   (href),
        .frame_sel (frame_sel),
        .req_ready (seq_ready),
        .req_valid (seq_valid),
        .req       (seq_req)
    );

    request_fifo i_request_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (seq_valid),
        .in_req    (seq_req),
        .in_ready  (seq_ready),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready),
        .out_req   (fifo_req)
    );

    ar_issuer i_ar_issuer (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (fifo_valid),
        .in_req      (fifo_req),
        .in_ready    (fifo_ready),
        .axi_arvalid (axi_arvalid),
        .axi_arready (axi_arready),
        .axi_araddr  (axi_araddr),
        .axi_arlen   (axi_arlen),
        .axi_arsize  (axi_arsize),
        .axi_arburst (axi_arburst),
        .axi_rready  (axi_rready),
        .axi_rvalid  (axi_rvalid),
        .axi_rdata   (axi_rdata),
        .axi_rlast   (axi_rlast),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_data (buf_wr_data)
    );

endmodule

// File: test/frame_reader_props.sv
/*
 * Concurrent checks bound into the AR issuer.
 * AXI address hold rule and one-cycle forwarding of read beats.
 */
`timescale 1ns/100ps

module frame_reader_props (
    input logic                          clk,
    input logic                          rst,
    input logic                          axi_arvalid,
    input logic                          axi_arready,
    input logic [axi_rd_pkg::ADDR_W-1:0] axi_araddr,
    input logic                          axi_rvalid,
    input logic                          buf_wr_en
);

    // request must wait for arready unchanged
    a_ar_hold: assert property (@(posedge clk) disable iff (!rst)
        axi_arvalid && !axi_arready |=> axi_arvalid && $stable(axi_araddr))
        else $error("AR request changed or dropped while arready was low");

    a_wr_follow: assert property (@(posedge clk) disable iff (!rst)
        axi_rvalid |=> buf_wr_en)
        else $error("read beat was not written to the line buffer");

    a_wr_idle: assert property (@(posedge clk) disable iff (!rst)
        !axi_rvalid |=> !buf_wr_en)
        else $error("line buffer write without a read beat");

endmodule

bind ar_issuer frame_reader_props i_frame_reader_props (
    .clk         (clk),
    .rst         (rst),
    .axi_arvalid (axi_arvalid),
    .axi_arready (axi_arready),
    .axi_araddr  (axi_araddr),
    .axi_rvalid  (axi_rvalid),
    .buf_wr_en   (buf_wr_en)
);

// File: test/tb_checker.sv
/*
 * Checker for the frame reader testbench.
 * Compares AR handshakes with the expected address queue, checks the burst
 * constants, rready and the read data forwarded to the line buffer port.
 * The testbench top fills the queue and brackets each test.
 */
`timescale 1ns/100ps

module tb_checker (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          axi_arvalid,
    input  logic                          axi_arready,
    input  logic [axi_rd_pkg::ADDR_W-1:0] axi_araddr,
    input  logic [3:0]                    axi_arlen,
    input  logic [2:0]                    axi_arsize,
    input  logic [1:0]                    axi_arburst,
    input  logic                          axi_rready,
    input  logic                          axi_rvalid,
    input  logic [axi_rd_pkg::DATA_W-1:0] axi_rdata,
    input  logic                          buf_wr_en,
    input  logic [axi_rd_pkg::DATA_W-1:0] buf_wr_data,
    output int                            ar_count,
    output int                            error_count,
    output logic                          timed_out
);

    logic [axi_rd_pkg::ADDR_W-1:0] exp_addr [$];
    logic [axi_rd_pkg::DATA_W-1:0] exp_data [$];   // beats owed to the line buffer
    logic [axi_rd_pkg::DATA_W-1:0] rdata_d   = '0;
    logic                          rvalid_d  = 1'b0;
    logic                          timeout_q = 1'b0;
    string test_name       = "reset";
    int    n_bursts        = 0;
    int    n_errors        = 0;
    int    n_checks        = 0;
    int    n_tests         = 0;
    int    n_failed        = 0;
    int    errors_at_start = 0;
    int    bursts_at_start = 0;
    int    cycles          = 0;
    int    cycle_limit     = 0;   // 0 until the trace is loaded

    assign ar_count    = n_bursts;
    assign error_count = n_errors;
    assign timed_out   = timeout_q;

    task automatic compare(input string what,
                           input logic [axi_rd_pkg::DATA_W-1:0] want,
                           input logic [axi_rd_pkg::DATA_W-1:0] got);
        n_checks++;
        if (want !== got) begin
            n_errors++;
            $display("Error %s: %s expected 0x%0h actual 0x%0h", test_name, what, want, got);
        end
    endtask

    task automatic report_problem(input string msg);
        n_errors++;
        $display("%s: %s", test_name, msg);
    endtask

    task automatic set_limit(input int n);
        cycle_limit = n;
    endtask

    task automatic expect_burst(input logic [axi_rd_pkg::ADDR_W-1:0] addr);
        exp_addr.push_back(addr);
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = n_errors;
        bursts_at_start = n_bursts;
    endtask

    task automatic end_test();
        if (exp_addr.size() != 0) begin
            report_problem($sformatf("%0d expected bursts were never issued", exp_addr.size()));
        end
        if (exp_data.size() != 0) begin
            report_problem($sformatf("%0d read beats never reached the line buffer",
                                     exp_data.size()));
        end
        exp_addr.delete();
        exp_data.delete();
        n_tests++;
        if (n_errors == errors_at_start) begin
            $display("test %s: ok, %0d bursts", test_name, n_bursts - bursts_at_start);
        end else begin
            n_failed++;
            $display("test %s: %0d errors", test_name, n_errors - errors_at_start);
        end
    endtask

    task automatic report_counts();
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d bursts",
                 n_tests, n_failed, n_checks, n_errors, n_bursts);
    endtask

    task automatic check_ar();
        logic [axi_rd_pkg::ADDR_W-1:0] want;
        int                            b;
        if (exp_addr.size() == 0) begin
            report_problem($sformatf("AR handshake at 0x%0h that no line job asked for",
                                     axi_araddr));
        end else begin
            want = exp_addr.pop_front();
            compare("araddr", axi_rd_pkg::DATA_W'(want), axi_rd_pkg::DATA_W'(axi_araddr));
            // slave pattern is address plus beat index
            for (b = 0; b < axi_rd_pkg::BURST_LEN; b++) begin
                exp_data.push_back(axi_rd_pkg::DATA_W'(want) + axi_rd_pkg::DATA_W'(b));
            end
        end
        // arlen counts beats minus one
        compare("arlen", axi_rd_pkg::DATA_W'(axi_rd_pkg::BURST_LEN - 1),
                axi_rd_pkg::DATA_W'(axi_arlen));
        compare("arsize", axi_rd_pkg::DATA_W'(axi_rd_pkg::BURST_SIZE_CODE),
                axi_rd_pkg::DATA_W'(axi_arsize));
        compare("arburst", axi_rd_pkg::DATA_W'(axi_rd_pkg::BURST_INCR),
                axi_rd_pkg::DATA_W'(axi_arburst));
        n_bursts++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            cycles++;
            if (axi_arvalid && axi_arready) begin
                check_ar();
            end
            if (axi_rvalid) begin
                compare("axi_rready", axi_rd_pkg::DATA_W'(1'b1),
                        axi_rd_pkg::DATA_W'(axi_rready));
            end
            if (buf_wr_en !== rvalid_d) begin
                report_problem("buf_wr_en does not follow axi_rvalid by one cycle");
            end
            if (buf_wr_en) begin
                if (exp_data.size() == 0) begin
                    report_problem("buffer write with no read beat outstanding");
                end else begin
                    compare("buf_wr_data", exp_data.pop_front(), buf_wr_data);
                end
                compare("buf_wr_data vs last rdata", rdata_d, buf_wr_data);
            end
            rvalid_d = axi_rvalid;
            rdata_d  = axi_rdata;
            if (cycle_limit > 0 && cycles >= cycle_limit && !timeout_q) begin
                $display("run timed out after %0d cycles in test %s", cycles, test_name);
                n_errors++;
                timeout_q = 1'b1;
                report_counts();
            end
        end
    end

endmodule

// File: test/tb_frame_reader.sv
/*
 * Testbench top for the frame reader.
 * Reads test records from test/read_trace.txt, drives vsync and href pulses,
 * models the AXI read slave and leaves all comparing to tb_checker.
 */
`timescale 1ns/100ps

module tb_frame_reader;

    logic                          clk;
    logic                          rst;
    logic                          vsync;
    logic                          href;
    logic                          frame_sel;
    logic                          axi_arready = 1'b0;
    logic                          axi_rvalid  = 1'b0;
    logic [axi_rd_pkg::DATA_W-1:0] axi_rdata   = '0;
    logic                          axi_rlast   = 1'b0;
    logic                          axi_arvalid;
    logic [axi_rd_pkg::ADDR_W-1:0] axi_araddr;
    logic [3:0]                    axi_arlen;
    logic [2:0]                    axi_arsize;
    logic [1:0]                    axi_arburst;
    logic                          axi_rready;
    logic                          buf_wr_en;
    logic [axi_rd_pkg::DATA_W-1:0] buf_wr_data;
    int                            ar_count;
    int                            error_count;
    logic                          timed_out;

    // parsed trace, one entry per test and per event line
    string t_name [$];
    int    t_fs [$];
    int    t_mode [$];
    int    t_first [$];
    int    t_events [$];
    string ev_kind [$];
    int    ev_jobs [$];
    int    ev_segs [$];
    int    ev_base [$];
    int    ev_sstride [$];
    int    ev_bursts [$];
    int    ev_lstride [$];

    logic [31:0]                   rnd_state    = 32'd74134;
    logic                          ready_random = 1'b0;
    logic [axi_rd_pkg::ADDR_W-1:0] pending [$];   // accepted bursts still owed data
    int                            beat_idx     = 0;

    frame_reader i_frame_reader (
        .clk         (clk),
        .rst         (rst),
        .vsync       (vsync),
        .href        (href),
        .frame_sel   (frame_sel),
        .axi_arvalid (axi_arvalid),
        .axi_arready (axi_arready),
        .axi_araddr  (axi_araddr),
        .axi_arlen   (axi_arlen),
        .axi_arsize  (axi_arsize),
        .axi_arburst (axi_arburst),
        .axi_rready  (axi_rready),
        .axi_rvalid  (axi_rvalid),
        .axi_rdata   (axi_rdata),
        .axi_rlast   (axi_rlast),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_data (buf_wr_data)
    );

    tb_checker i_checker (
        .clk         (clk),
        .rst         (rst),
        .axi_arvalid (axi_arvalid),
        .axi_arready (axi_arready),
        .axi_araddr  (axi_araddr),
        .axi_arlen   (axi_arlen),
        .axi_arsize  (axi_arsize),
        .axi_arburst (axi_arburst),
        .axi_rready  (axi_rready),
        .axi_rvalid  (axi_rvalid),
        .axi_rdata   (axi_rdata),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_data (buf_wr_data),
        .ar_count    (ar_count),
        .error_count (error_count),
        .timed_out   (timed_out)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // read slave and arready pattern
    always @(posedge clk) begin
        if (rst && axi_arvalid && axi_arready) begin
            pending.push_back(axi_araddr);
        end
        #5;
        if (ready_random) begin
            rnd_state   = next_random(rnd_state);
            axi_arready = rnd_state[0];
        end else begin
            axi_arready = 1'b1;
        end
        if (pending.size() > 0) begin
            axi_rvalid = 1'b1;
            axi_rdata  = axi_rd_pkg::DATA_W'(pending[0]) + axi_rd_pkg::DATA_W'(beat_idx);
            axi_rlast  = (beat_idx == axi_rd_pkg::BURST_LEN - 1);
            if (axi_rlast) begin
                void'(pending.pop_front());
                beat_idx = 0;
            end else begin
                beat_idx++;
            end
        end else begin
            axi_rvalid = 1'b0;
            axi_rlast  = 1'b0;
        end
    end

    // stop at once when the checker gives up
    initial begin
        wait (timed_out === 1'b1);
        $display("TB FAILED");
        $finish;
    end

    task automatic load_trace(output int total);
        int    fd;
        int    n;
        string line;
        string tok;
        string name;
        string kind;
        int    fs;
        int    mode;
        int    v [6];
        total = 0;
        fd = $fopen("test/read_trace.txt", "r");
        if (fd == 0) begin
            i_checker.report_problem("could not open test/read_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s", tok);
                    if (tok == "test") begin
                        n = $sscanf(line, "%s %s %d %d", tok, name, fs, mode);
                        t_name.push_back(name);
                        t_fs.push_back(fs);
                        t_mode.push_back(mode);
                        t_first.push_back(ev_kind.size());
                        t_events.push_back(0);
                    end else begin
                        n = $sscanf(line, "%s %d %d %d %d %d %d",
                                    kind, v[0], v[1], v[2], v[3], v[4], v[5]);
                        ev_kind.push_back(kind);
                        ev_jobs.push_back(v[0]);
                        ev_segs.push_back(v[1]);
                        ev_base.push_back(v[2]);
                        ev_sstride.push_back(v[3]);
                        ev_bursts.push_back(v[4]);
                        ev_lstride.push_back(v[5]);
                        t_events[t_events.size()-1]++;
                        total += v[0] * v[1] * v[4];
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // a falling edge at the end of the pulse starts the line job
    task automatic sync_pulse(input logic on_vsync);
        @(posedge clk);
        #5;
        if (on_vsync) begin
            vsync = 1'b1;
        end else begin
            href = 1'b1;
        end
        repeat (4) @(posedge clk);
        #5;
        vsync = 1'b0;
        href  = 1'b0;
    endtask

    task automatic run_test(input int t);
        int e;
        int j;
        int s;
        int b;
        int n_exp;
        int target;
        i_checker.begin_test(t_name[t]);
        @(negedge clk);
        ready_random = (t_mode[t] == 1);
        @(posedge clk);
        #5 frame_sel = t_fs[t][0];
        for (e = t_first[t]; e < t_first[t] + t_events[t]; e++) begin
            for (j = 0; j < ev_jobs[e]; j++) begin
                n_exp = 0;
                for (s = 0; s < ev_segs[e]; s++) begin
                    for (b = 0; b < ev_bursts[e]; b++) begin
                        i_checker.expect_burst(axi_rd_pkg::ADDR_W'(ev_base[e]
                            + s * ev_sstride[e] + j * ev_lstride[e]
                            + b * axi_rd_pkg::ADDR_STEP));
                        n_exp++;
                    end
                end
                target = ar_count + n_exp;
                sync_pulse(ev_kind[e] == "V");
                if (n_exp == 0) begin
                    repeat (40) @(negedge clk);   // give a stray burst time to show
                end else begin
                    while (ar_count < target) @(negedge clk);
                end
            end
        end
        while (pending.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        i_checker.end_test();
    endtask

    initial begin
        int total;
        int t;
        clk       = 1'b0;
        rst       = 1'b0;
        vsync     = 1'b0;
        href      = 1'b0;
        frame_sel = 1'b0;
        load_trace(total);
        i_checker.set_limit(total * 40 + 2000);
        repeat (16) @(posedge clk);
        #5 rst = 1'b1;
        for (t = 0; t < t_name.size(); t++) begin
            run_test(t);
        end
        i_checker.report_counts();
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: test/read_trace.txt
# test <name> <frame_sel> <arready mode: 0 always high, 1 random>
# <V vsync pulse | H href pulse> <jobs> <segments> <base> <segment stride> <bursts> <line stride>
# burst address = base + segment * segment stride + job * line stride + burst * 16
test frame0_order 0 0
V 1 4 0 2048 2 32
H 3 4 32 2048 2 32
H 6 1 8192 0 6 96
test frame1_offsets 1 0
V 1 4 1024 2048 2 32
H 3 4 1056 2048 2 32
H 6 1 12288 0 6 96
test backpressure 0 1
V 1 4 0 2048 2 32
H 3 4 32 2048 2 32
H 6 1 8192 0 6 96
test vsync_restart 0 0
V 1 4 0 2048 2 32
H 1 4 32 2048 2 32
V 1 4 0 2048 2 32
H 1 4 32 2048 2 32
test frame_done 0 1
V 1 4 0 2048 2 32
H 3 4 32 2048 2 32
H 6 1 8192 0 6 96
H 3 0 0 0 0 0

// File: sim.f
design/axi_rd_pkg.sv
design/video_pkg.sv
design/line_sequencer.sv
design/request_fifo.sv
design/ar_issuer.sv
design/frame_reader.sv
test/frame_reader_props.sv
test/tb_checker.sv
test/tb_frame_reader.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the frame reader testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_frame_reader -f sim.f -o sim_frame_reader

./obj_dir/sim_frame_reader 2>&1 | tee sim.log

if grep -qx "TB PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi
